// File: source/opl_pg_pkg.sv
`default_nettype none

package opl_pg_pkg;

    // Slot index, room for up to 32 operator slots
    typedef logic [4:0] slot_t;
    // Channel frequency number
    typedef logic [9:0] fnum_t;
    // Octave
    typedef logic [2:0] block_t;
    // Multiplier code as written by the host
    typedef logic [3:0] mul_t;
    // Block and top fnum bit
    typedef logic [3:0] kc_t;
    // Increment before the multiplier
    typedef logic [16:0] phinc_t;
    // Full phase accumulator
    typedef logic [19:0] phase_t;
    // Phase seen by the operator, top ten accumulator bits
    typedef logic [9:0] phase_op_t;

    // One output bundle per slot tick
    typedef struct packed {
        slot_t     slot;
        kc_t       kc;
        phase_op_t phase;
    } pg_out_t;

    // Twice the frequency multiple, so code 0 stays an integer
    function automatic logic [4:0] mul_factor(input mul_t code);
        logic [4:0] f;
        case (code)
            4'd0:    f = 5'd1;
            4'd11:   f = 5'd20;
            4'd12,
            4'd13:   f = 5'd24;
            4'd14,
            4'd15:   f = 5'd30;
            // Codes 1 to 10 scale linearly
            default: f = {code, 1'b0};
        endcase
        return f;
    endfunction

endpackage

`default_nettype wire

// File: source/opl_sh_rst.sv
`default_nettype none

module opl_sh_rst #(
    parameter type payload_t = logic [7:0],
    parameter int  STAGES    = 2
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     cen,
    input  wire payload_t din,
    output payload_t      drop
);

    payload_t sr [STAGES];

    // Shift only on enable ticks, hold otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STAGES; i++)
                sr[i] <= '0;
        end else if (cen) begin
            sr[0] <= din;
            for (int i = 1; i < STAGES; i++)
                sr[i] <= sr[i-1];
        end
    end

    // Oldest entry
    assign drop = sr[STAGES-1];

endmodule

`default_nettype wire

// File: source/opl_pg_comb.sv
`default_nettype none

module opl_pg_comb import opl_pg_pkg::*; (
    // Stage I inputs
    input  wire fnum_t      fnum,
    input  wire block_t     block,
    input  wire logic [6:0] lfo_mod,
    input  wire logic       vib,
    input  wire logic       dvb,
    // Stage II inputs
    input  wire mul_t       mul,
    input  wire phinc_t     phinc_in,
    input  wire phase_t     phase_in,
    input  wire logic       pg_rst,
    // Stage I results
    output kc_t             keycode,
    output phinc_t          phinc_out,
    // Stage II results
    output phase_t          phase_out,
    output phase_op_t       phase_op
);

    logic [3:0]  vib_mag;
    logic        vib_neg;
    logic [6:0]  vib_prod;
    logic [3:0]  vib_off;
    fnum_t       fnum_mod;
    phinc_t      phinc_sh;
    logic [4:0]  factor;
    logic [21:0] prod;
    phase_t      step;

    // Keycode uses fnum bit 9 only
    assign keycode = {block, fnum[9]};

    // LFO word split into magnitude and sign
    assign vib_mag = lfo_mod[5:2];
    assign vib_neg = lfo_mod[6];

    always_comb begin
        // Offset scales with the top three fnum bits
        vib_prod = fnum[9:7] * vib_mag;
        // Deep vibrato keeps one more bit
        if (dvb)
            vib_off = vib_prod[6:3];
        else
            vib_off = {1'b0, vib_prod[6:4]};
        // Wraps modulo 1024
        if (!vib)
            fnum_mod = fnum;
        else if (vib_neg)
            fnum_mod = fnum - fnum_t'(vib_off);
        else
            fnum_mod = fnum + fnum_t'(vib_off);
    end

    always_comb begin
        // Block 7 lands on bit 16 at most
        phinc_sh  = phinc_t'(fnum_mod) << block;
        phinc_out = phinc_sh >> 1;
    end

    // Multiplier table gives twice the factor
    assign factor = mul_factor(mul);

    always_comb begin
        prod = phinc_in * factor;
        // Undo the doubling
        step = phase_t'(prod[21:1]);
        // Key-on forces a fresh start
        if (pg_rst)
            phase_out = '0;
        else
            phase_out = phase_in + step;
    end

    // Operator sees the top bits only
    assign phase_op = phase_out[19:10];

endmodule

`default_nettype wire

// File: source/opl_pg_regs.sv
`default_nettype none

module opl_pg_regs import opl_pg_pkg::*; #(
    parameter int CH = 9
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       cen,
    input  wire slot_t      slot,
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire logic       wb_we,
    input  wire logic [7:0] wb_adr,
    input  wire logic [7:0] wb_dat_w,
    output logic      [7:0] wb_dat_r,
    output logic            wb_ack,
    output fnum_t           fnum,
    output block_t          block,
    output mul_t            mul,
    output logic            vib,
    output logic            dvb,
    output logic            pg_rst
);

    // Per-slot fields
    mul_t   mul_r [2*CH];
    logic   vib_r [2*CH];
    // Per-channel fields
    fnum_t  fnum_r [CH];
    block_t block_r [CH];
    logic   kon_r [CH];
    logic   dvb_r;
    // Phase reset waiting for its slot
    logic [2*CH-1:0] pend;

    logic       access;
    logic       wr_en;
    logic       sel_slot;
    logic       sel_flo;
    logic       sel_fhi;
    logic       sel_dvb;
    slot_t      adr_slot;
    logic [3:0] adr_ch;
    logic [7:0] rd_nxt;
    logic [3:0] ch;

    // New cycle seen while no ack outstanding
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_en  = access && wb_we;

    // Address decode, out-of-range slots and channels fall through
    assign adr_slot = slot_t'(wb_adr[4:0]);
    assign adr_ch   = wb_adr[3:0];
    assign sel_slot = (wb_adr[7:5] == 3'b000) && (int'(adr_slot) < 2*CH);
    assign sel_flo  = (wb_adr[7:4] == 4'h2) && (int'(adr_ch) < CH);
    assign sel_fhi  = (wb_adr[7:4] == 4'h3) && (int'(adr_ch) < CH);
    assign sel_dvb  = (wb_adr == 8'h40);

    always_comb begin
        rd_nxt = 8'h00;
        if (sel_slot)
            rd_nxt = {1'b0, vib_r[adr_slot], 2'b00, mul_r[adr_slot]};
        else if (sel_flo)
            rd_nxt = fnum_r[adr_ch][7:0];
        else if (sel_fhi)
            rd_nxt = {2'b00, kon_r[adr_ch], block_r[adr_ch], fnum_r[adr_ch][9:8]};
        else if (sel_dvb)
            rd_nxt = {7'd0, dvb_r};
    end

    // Single-cycle ack, read data captured alongside
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= 8'h00;
        end else begin
            wb_ack <= access;
            if (access)
                wb_dat_r <= rd_nxt;
        end
    end

    // Register file, visible from the ack cycle on
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2*CH; i++) begin
                mul_r[i] <= '0;
                vib_r[i] <= 1'b0;
            end
            for (int i = 0; i < CH; i++) begin
                fnum_r[i]  <= '0;
                block_r[i] <= '0;
                kon_r[i]   <= 1'b0;
            end
            dvb_r <= 1'b0;
        end else if (wr_en) begin
            if (sel_slot) begin
                mul_r[adr_slot] <= wb_dat_w[3:0];
                vib_r[adr_slot] <= wb_dat_w[6];
            end
            if (sel_flo)
                fnum_r[adr_ch][7:0] <= wb_dat_w;
            if (sel_fhi) begin
                fnum_r[adr_ch][9:8] <= wb_dat_w[1:0];
                block_r[adr_ch]     <= wb_dat_w[4:2];
                kon_r[adr_ch]       <= wb_dat_w[5];
            end
            if (sel_dvb)
                dvb_r <= wb_dat_w[0];
        end
    end

    // Key-on edge arms both operators, served slot clears its own flag
    // set wins over clear on a shared edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend <= '0;
        end else begin
            if (cen)
                pend[slot] <= 1'b0;
            if (wr_en && sel_fhi && wb_dat_w[5] && !kon_r[adr_ch]) begin
                pend[{adr_ch, 1'b0}] <= 1'b1;
                pend[{adr_ch, 1'b1}] <= 1'b1;
            end
        end
    end

    // Stage I view of the current slot
    assign ch     = slot[4:1];
    assign fnum   = fnum_r[ch];
    assign block  = block_r[ch];
    assign mul    = mul_r[slot];
    assign vib    = vib_r[slot];
    assign dvb    = dvb_r;
    assign pg_rst = pend[slot];

    a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// File: source/opl_pg.sv
`default_nettype none

module opl_pg import opl_pg_pkg::*; #(
    parameter int CH  = 9,
    parameter int PAD = 2
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       cen,
    input  wire slot_t      slot,
    input  wire fnum_t      fnum,
    input  wire block_t     block,
    input  wire mul_t       mul,
    input  wire logic       vib,
    input  wire logic       dvb,
    input  wire logic [6:0] lfo_mod,
    input  wire logic       pg_rst,
    output slot_t           out_slot,
    output kc_t             out_kc,
    output phase_op_t       out_phase
);

    kc_t       kc_i;
    phinc_t    phinc_i;
    // Stage II registers
    phinc_t    phinc_ii;
    kc_t       kc_ii;
    mul_t      mul_ii;
    logic      rst_ii;
    slot_t     slot_ii;
    phase_t    phase_ii;
    // Ring tap and sum
    phase_t    phase_drop;
    phase_t    phase_sum;
    phase_op_t phase_op_ii;
    pg_out_t   bundle_ii;
    pg_out_t   bundle_out;

    opl_pg_comb u_comb (
        .fnum      (fnum),
        .block     (block),
        .lfo_mod   (lfo_mod),
        .vib       (vib),
        .dvb       (dvb),
        .mul       (mul_ii),
        .phinc_in  (phinc_ii),
        .phase_in  (phase_ii),
        .pg_rst    (rst_ii),
        .keycode   (kc_i),
        .phinc_out (phinc_i),
        .phase_out (phase_sum),
        .phase_op  (phase_op_ii)
    );

    // Ring tap lines up with stage I and is captured with the rest
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phinc_ii <= '0;
            kc_ii    <= '0;
            mul_ii   <= '0;
            rst_ii   <= 1'b0;
            slot_ii  <= '0;
            phase_ii <= '0;
        end else if (cen) begin
            phinc_ii <= phinc_i;
            kc_ii    <= kc_i;
            mul_ii   <= mul;
            rst_ii   <= pg_rst;
            slot_ii  <= slot;
            phase_ii <= phase_drop;
        end
    end

    // One round of phases minus the stage II capture
    opl_sh_rst #(.payload_t(phase_t), .STAGES(2*CH-1)) u_ring (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .din    (phase_sum),
        .drop   (phase_drop)
    );

    assign bundle_ii = '{slot: slot_ii, kc: kc_ii, phase: phase_op_ii};

    // Output alignment delay
    opl_sh_rst #(.payload_t(pg_out_t), .STAGES(PAD)) u_pad (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .din    (bundle_ii),
        .drop   (bundle_out)
    );

    assign out_slot  = bundle_out.slot;
    assign out_kc    = bundle_out.kc;
    assign out_phase = bundle_out.phase;

    // Ring length relies on stage I running one slot ahead of stage II
    a_slot_follow: assert property (@(posedge clk) disable iff (!arst_n)
        cen |=> slot == ((slot_ii == slot_t'(2*CH-1)) ? '0 : slot_ii + 1'b1));

endmodule

`default_nettype wire

// File: source/opl_pg_top.sv
`default_nettype none

module opl_pg_top import opl_pg_pkg::*; #(
    parameter int CH  = 9,
    parameter int PAD = 2
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       cen,
    input  wire logic [6:0] lfo_mod,
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire logic       wb_we,
    input  wire logic [7:0] wb_adr,
    input  wire logic [7:0] wb_dat_w,
    output logic      [7:0] wb_dat_r,
    output logic            wb_ack,
    output slot_t           out_slot,
    output kc_t             out_kc,
    output phase_op_t       out_phase
);

    // Last operator slot
    localparam slot_t SLOT_LAST = slot_t'(2*CH-1);

    slot_t  slot_cnt;
    fnum_t  fnum;
    block_t block;
    mul_t   mul;
    logic   vib;
    logic   dvb;
    logic   pg_rst;

    // Slot sequencer, one step per enable tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            slot_cnt <= '0;
        else if (cen)
            slot_cnt <= (slot_cnt == SLOT_LAST) ? '0 : slot_cnt + 1'b1;
    end

    opl_pg_regs #(.CH(CH)) u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .cen      (cen),
        .slot     (slot_cnt),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .fnum     (fnum),
        .block    (block),
        .mul      (mul),
        .vib      (vib),
        .dvb      (dvb),
        .pg_rst   (pg_rst)
    );

    opl_pg #(.CH(CH), .PAD(PAD)) u_pg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cen       (cen),
        .slot      (slot_cnt),
        .fnum      (fnum),
        .block     (block),
        .mul       (mul),
        .vib       (vib),
        .dvb       (dvb),
        .lfo_mod   (lfo_mod),
        .pg_rst    (pg_rst),
        .out_slot  (out_slot),
        .out_kc    (out_kc),
        .out_phase (out_phase)
    );

    // Register file and phase ring assume the counter stays in range
    a_slot_range: assert property (@(posedge clk) disable iff (!arst_n)
        slot_cnt <= SLOT_LAST);

endmodule

`default_nettype wire

// File: verif/opl_pg_tb_tasks.svh
`ifndef OPL_PG_TB_TASKS_SVH
`define OPL_PG_TB_TASKS_SVH

// Register image
mul_t   m_mul   [2*CH];
logic   m_vib   [2*CH];
logic   m_pend  [2*CH];
fnum_t  m_fnum  [CH];
block_t m_blk   [CH];
logic   m_kon   [CH];
logic   m_dvb;
// Phase per slot and slot counter
phase_t m_phase [2*CH];
slot_t  m_slot;
// Slot sitting in stage II
slot_t  s2_slot;
int     s2_inc;
kc_t    s2_kc;
mul_t   s2_mul;
logic   s2_rst;
// Output pad contents, oldest first
pg_out_t pad_q [$];
// Twice the frequency multiple per code
int mul_x2 [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

task automatic model_reset();
    pg_out_t z;
    z = '0;
    for (int i = 0; i < 2*CH; i++) begin
        m_mul[i]   = '0;
        m_vib[i]   = 1'b0;
        m_pend[i]  = 1'b0;
        m_phase[i] = '0;
    end
    for (int i = 0; i < CH; i++) begin
        m_fnum[i] = '0;
        m_blk[i]  = '0;
        m_kon[i]  = 1'b0;
    end
    m_dvb   = 1'b0;
    m_slot  = '0;
    s2_slot = '0;
    s2_inc  = 0;
    s2_kc   = '0;
    s2_mul  = '0;
    s2_rst  = 1'b0;
    pad_q.delete();
    repeat (PAD) pad_q.push_back(z);
endtask

// Increment after vibrato and block shift
function automatic int calc_inc(input fnum_t fn, input block_t blk, input logic vib,
                                input logic dvb, input logic [6:0] lfo);
    int f;
    int off;
    f   = int'(fn);
    off = int'(fn[9:7]) * int'(lfo[5:2]);
    off = dvb ? (off >> 3) : (off >> 4);
    if (vib)
        f = lfo[6] ? ((f - off) & 1023) : ((f + off) & 1023);
    return (f << blk) >> 1;
endfunction

// Stage II sum, pad shift, then stage I capture
task automatic model_tick();
    int      sum;
    int      ch;
    phase_t  nxt;
    pg_out_t b;
    if (s2_rst) begin
        nxt = '0;
    end else begin
        sum = int'(m_phase[s2_slot]) + (s2_inc * mul_x2[s2_mul]) / 2;
        nxt = phase_t'(sum);
    end
    m_phase[s2_slot] = nxt;
    b.slot  = s2_slot;
    b.kc    = s2_kc;
    b.phase = nxt[19:10];
    pad_q.push_back(b);
    void'(pad_q.pop_front());
    ch      = int'(m_slot) / 2;
    s2_slot = m_slot;
    s2_kc   = {m_blk[ch], m_fnum[ch][9]};
    s2_mul  = m_mul[m_slot];
    s2_rst  = m_pend[m_slot];
    s2_inc  = calc_inc(m_fnum[ch], m_blk[ch], m_vib[m_slot], m_dvb, lfo_mod);
    m_pend[m_slot] = 1'b0;
    m_slot  = (int'(m_slot) == 2*CH-1) ? '0 : slot_t'(m_slot + 1);
endtask

task automatic model_write(input logic [7:0] adr, input logic [7:0] dat);
    int a;
    int ch;
    a = int'(adr);
    if (a < 2*CH) begin
        m_mul[a] = dat[3:0];
        m_vib[a] = dat[6];
    end else if (a >= 32'h20 && a < 32'h20 + CH) begin
        m_fnum[a-32'h20][7:0] = dat;
    end else if (a >= 32'h30 && a < 32'h30 + CH) begin
        ch = a - 32'h30;
        // Rising key-on arms both operators
        if (dat[5] && !m_kon[ch]) begin
            m_pend[2*ch]   = 1'b1;
            m_pend[2*ch+1] = 1'b1;
        end
        m_fnum[ch][9:8] = dat[1:0];
        m_blk[ch]       = dat[4:2];
        m_kon[ch]       = dat[5];
    end else if (a == 32'h40) begin
        m_dvb = dat[0];
    end
endtask

function automatic logic [7:0] model_read(input logic [7:0] adr);
    int a;
    a = int'(adr);
    if (a < 2*CH)
        return {1'b0, m_vib[a], 2'b00, m_mul[a]};
    if (a >= 32'h20 && a < 32'h20 + CH)
        return m_fnum[a-32'h20][7:0];
    if (a >= 32'h30 && a < 32'h30 + CH)
        return {2'b00, m_kon[a-32'h30], m_blk[a-32'h30], m_fnum[a-32'h30][9:8]};
    if (a == 32'h40)
        return {7'd0, m_dvb};
    return 8'h00;
endfunction

// Classic single write, image updated on ack
task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    next_cycle();
    while (!wb_ack) begin
        waited++;
        if (waited > 8)
            abort_run($sformatf("No ack for the write to address %h", adr));
        else
            next_cycle();
    end
    model_write(adr, dat);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
endtask

task automatic wb_read(input logic [7:0] adr, output logic [7:0] rd);
    int waited;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    waited = 0;
    next_cycle();
    while (!wb_ack) begin
        waited++;
        if (waited > 8)
            abort_run($sformatf("No ack for the read from address %h", adr));
        else
            next_cycle();
    end
    // Data only valid alongside ack
    rd     = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    next_cycle();
endtask

task automatic check_slot(input slot_t got, input slot_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t: out_slot %0d, expected %0d", $time, got, exp));
endtask

task automatic check_kc(input slot_t slot, input kc_t got, input kc_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t: slot %0d keycode %h, expected %h",
            $time, slot, got, exp));
endtask

task automatic check_phase(input slot_t slot, input phase_op_t got, input phase_op_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t: slot %0d phase %h, expected %h",
            $time, slot, got, exp));
endtask

task automatic check_rdata(input logic [7:0] adr, input logic [7:0] got,
                           input logic [7:0] exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t: read of address %h gave %h, expected %h",
            $time, adr, got, exp));
endtask

`endif

// File: verif/opl_pg_tb.sv
`default_nettype none

module opl_pg_tb import opl_pg_pkg::*;;

    localparam int CH   = 9;
    localparam int PAD  = 2;
    localparam int ROWS = 9;
    localparam int WR_N = 44;

    logic       clk;
    logic       arst_n;
    logic       cen;
    logic [6:0] lfo_mod;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [7:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    slot_t      out_slot;
    kc_t        out_kc;
    phase_op_t  out_phase;

    // Random cen gaps
    int seed;
    // Watchdog
    int cycles = 0;
    int limit;

    // Register writes, address in the high byte and data in the low byte
    logic [15:0] wr_list [WR_N] = '{
        // Row 1, multipliers incl. code 0 and 10 to 15, masked bits
        16'h00_00, 16'h01_0a, 16'h02_0b, 16'h03_0c, 16'h04_0d, 16'h05_0e,
        16'h06_ff, 16'h07_b1, 16'h10_03, 16'h11_07,
        // Row 1, fnum and block per channel
        16'h20_41, 16'h30_d2, 16'h21_ff, 16'h31_1f, 16'h22_80, 16'h32_01,
        16'h23_55, 16'h33_0e, 16'h28_33, 16'h38_0b,
        // Row 1, unmapped
        16'h12_ff, 16'h29_77, 16'h41_01,
        // Row 2, key-on ch0 and ch3
        16'h30_32, 16'h33_2e,
        // Row 3, key-on again while set
        16'h30_32, 16'h20_90,
        // Row 4, key-off then key-on in one batch
        16'h30_12, 16'h30_32,
        // Row 5, vibrato enables
        16'h00_40, 16'h01_4a, 16'h02_41, 16'h05_4e, 16'h07_41, 16'h40_00,
        // Row 6, deep vibrato
        16'h40_01,
        // Row 7
        16'h40_00, 16'h04_4d,
        // Row 8, keycode spread
        16'h24_00, 16'h34_1e, 16'h25_ff, 16'h35_05, 16'h08_42, 16'h40_01
    };

    // Stimulus table, one entry per row
    int         row_first  [ROWS] = '{0, 0, 23, 25, 27, 29, 35, 36, 38};
    int         row_cnt    [ROWS] = '{0, 23, 2, 2, 2, 6, 1, 2, 6};
    logic [6:0] row_lfo    [ROWS] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                                      7'h3c, 7'h7c, 7'h5c, 7'h24};
    bit         row_gaps   [ROWS] = '{0, 0, 1, 0, 1, 0, 1, 1, 1};
    int         row_rounds [ROWS] = '{2, 24, 6, 6, 4, 6, 6, 6, 8};

    opl_pg_top #(.CH(CH), .PAD(PAD)) opl_pg_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cen       (cen),
        .lfo_mod   (lfo_mod),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_slot  (out_slot),
        .out_kc    (out_kc),
        .out_phase (out_phase)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit)
            abort_run($sformatf("Timeout after %0d clock cycles, the run did not finish",
                cycles));
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // One clock, then model update and output compare
    task automatic next_cycle();
        logic ticked;
        ticked = cen;
        @(posedge clk);
        #1;
        if (ticked)
            model_tick();
        check_slot(out_slot, pad_q[0].slot);
        check_kc(out_slot, out_kc, pad_q[0].kc);
        check_phase(out_slot, out_phase, pad_q[0].phase);
    endtask

    // Writes with readback, then free run for the row's rounds
    task automatic run_row(input int r);
        int         ticks;
        int         w;
        logic [7:0] adr;
        logic [7:0] dat;
        logic [7:0] rd;
        for (w = row_first[r]; w < row_first[r] + row_cnt[r]; w++) begin
            adr = wr_list[w][15:8];
            dat = wr_list[w][7:0];
            wb_write(adr, dat);
            wb_read(adr, rd);
            check_rdata(adr, rd, model_read(adr));
        end
        lfo_mod = row_lfo[r];
        ticks = 0;
        while (ticks < row_rounds[r] * 2 * CH) begin
            // About one cycle in four idle
            if (row_gaps[r] && (($random(seed) & 3) == 0))
                cen = 1'b0;
            else
                cen = 1'b1;
            next_cycle();
            if (cen)
                ticks++;
        end
        cen = 1'b0;
        next_cycle();
    endtask

    `include "opl_pg_tb_tasks.svh"

    initial begin
        logic [7:0] rd;
        int         r;
        int         a;
        clk      = 1'b0;
        arst_n   = 1'b0;
        cen      = 1'b0;
        lfo_mod  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 43;
        // Rounds with gap slack, bus traffic, final sweep
        limit = 500 + 256 * 4;
        for (r = 0; r < ROWS; r++)
            limit += row_rounds[r] * 2 * CH * 4 + row_cnt[r] * 12;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (r = 0; r < ROWS; r++)
            run_row(r);
        // Whole address space, unmapped reads zero
        for (a = 0; a < 256; a++) begin
            wb_read(8'(a), rd);
            check_rdata(8'(a), rd, model_read(8'(a)));
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
source/opl_pg_pkg.sv
source/opl_sh_rst.sv
source/opl_pg_comb.sv
source/opl_pg_regs.sv
source/opl_pg.sv
source/opl_pg_top.sv
verif/opl_pg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the phase generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module opl_pg_tb \
    -o opl_pg_sim > build.log 2>&1 \
    || { cat build.log; echo "run_sim: build error"; exit 1; }

./obj_dir/opl_pg_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "Simulation failed" "$LOG" && { echo "run_sim: FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" \
    && { echo "run_sim: PASS"; exit 0; } \
    || { echo "run_sim: no result in $LOG"; exit 1; }
